//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// major opcodes, instruction[30:25]
`define CPU_TY_BASE 6'b100000
`define CPU_ADDI 6'b101000
`define CPU_ORI 6'b101100
`define CPU_XORI 6'b101011
`define CPU_MOVI 6'b100010
`define CPU_LWI 6'b000010
`define CPU_SWI 6'b001010
`define CPU_TY_LS 6'b011100
`define CPU_TY_B 6'b100110
`define CPU_JJ 6'b100100

// base group, instruction[4:0]
`define CPU_ADD 5'b00000
`define CPU_SUB 5'b00001
`define CPU_AND 5'b00010
`define CPU_XOR 5'b00011
`define CPU_OR 5'b00100
`define CPU_SLLI 5'b01000
`define CPU_SRLI 5'b01001
`define CPU_ROTRI 5'b01011

// load/store group, instruction[7:0]
`define CPU_LW 8'b00000010
`define CPU_SW 8'b00001010

// branch group, instruction[14]
`define CPU_BEQ 1'b0
`define CPU_BNE 1'b1

`define CPU_F_OPCODE 30:25
`define CPU_F_RT 24:20
`define CPU_F_RA 19:15
`define CPU_F_RB 14:10
`define CPU_F_SUB_BASE 4:0
`define CPU_F_SUB_LS 7:0
`define CPU_F_SUB_B 14
`define CPU_F_IMM5 14:10
`define CPU_F_IMM14 13:0
`define CPU_F_IMM15 14:0
`define CPU_F_IMM20 19:0
`define CPU_F_IMM24 23:0

// alu operation codes
`define CPU_ALU_ADD 4'd0
`define CPU_ALU_SUB 4'd1
`define CPU_ALU_AND 4'd2
`define CPU_ALU_OR 4'd3
`define CPU_ALU_XOR 4'd4
`define CPU_ALU_SRL 4'd5
`define CPU_ALU_SLL 4'd6
`define CPU_ALU_ROTR 4'd7

`define CPU_IMEM_DEPTH 64
`define CPU_DMEM_DEPTH 32

`endif

//--- cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// word-granular program counter
	typedef logic [7:0] pc_t;

	// 0 sequential, 1 branch, 2 jump
	typedef logic [1:0] pc_sel_t;

	// 0 rb, 1 ext imm, 2 imm15 offset, 3 rb index, 4 rt compare
	typedef logic [2:0] alu_src2_t;

	// 0 shamt, 1 sext15, 2 zext15, 3 sext20
	typedef logic [1:0] imm_ext_t;

	// 0 alu, 1 imm, 2 memory
	typedef logic [1:0] wb_sel_t;

	typedef enum logic [2:0] {
		s_fetch,
		s_decode,
		s_execute,
		s_memaccess,
		s_writeback,
		s_pc_update
	} cpu_state_t;

endpackage

//--- controller.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module controller (
	input logic clock,
	input logic reset,
	input cpu_pkg::word_t instruction,
	input logic alu_zero,
	output logic enable_fetch,
	output logic enable_decode,
	output logic enable_execute,
	output logic enable_memaccess,
	output logic enable_writeback,
	output logic enable_pc,
	output cpu_pkg::pc_sel_t pc_select,
	output cpu_pkg::alu_src2_t alu_src2_select,
	output cpu_pkg::imm_ext_t imm_extend_select,
	output cpu_pkg::wb_sel_t write_reg_select,
	output logic [3:0] alu_op,
	output logic dm_read,
	output logic dm_write,
	output logic do_reg_write,
	output cpu_pkg::reg_addr_t reg_ra_addr,
	output cpu_pkg::reg_addr_t reg_rb_addr,
	output cpu_pkg::reg_addr_t reg_rt_addr
);
	import cpu_pkg::*;

	cpu_state_t state;
	cpu_state_t next_state;
	logic [5:0] opcode;
	logic [4:0] sub_base;
	logic [7:0] sub_ls;
	logic sub_b;

	assign opcode = instruction[`CPU_F_OPCODE];
	assign sub_base = instruction[`CPU_F_SUB_BASE];
	assign sub_ls = instruction[`CPU_F_SUB_LS];
	assign sub_b = instruction[`CPU_F_SUB_B];
	assign reg_ra_addr = instruction[`CPU_F_RA];
	assign reg_rb_addr = instruction[`CPU_F_RB];
	assign reg_rt_addr = instruction[`CPU_F_RT];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= s_fetch;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		enable_fetch = 1'b0;
		enable_decode = 1'b0;
		enable_execute = 1'b0;
		enable_memaccess = 1'b0;
		enable_writeback = 1'b0;
		enable_pc = 1'b0;
		next_state = s_fetch;
		case (state)
			s_fetch: begin
				enable_fetch = 1'b1;
				next_state = s_decode;
			end
			s_decode: begin
				enable_decode = 1'b1;
				next_state = s_execute;
			end
			s_execute: begin
				enable_execute = 1'b1;
				next_state = s_memaccess;
			end
			s_memaccess: begin
				enable_memaccess = 1'b1;
				next_state = s_writeback;
			end
			s_writeback: begin
				enable_writeback = 1'b1;
				next_state = s_pc_update;
			end
			default: begin
				enable_pc = 1'b1;
				next_state = s_fetch;
			end
		endcase
	end

	// alu_zero is the registered result of ra - rt
	always_comb begin
		pc_select = 2'd0;
		if (opcode == `CPU_JJ) begin
			pc_select = 2'd2;
		end else if (opcode == `CPU_TY_B) begin
			if ((sub_b == `CPU_BEQ && alu_zero) || (sub_b == `CPU_BNE && !alu_zero)) begin
				pc_select = 2'd1;
			end
		end
	end

	always_comb begin
		alu_src2_select = 3'd0;
		imm_extend_select = 2'd0;
		write_reg_select = 2'd0;
		alu_op = `CPU_ALU_ADD;
		dm_read = 1'b0;
		dm_write = 1'b0;
		do_reg_write = 1'b0;
		case (opcode)
			`CPU_TY_BASE: begin
				do_reg_write = 1'b1;
				case (sub_base)
					`CPU_ADD: alu_op = `CPU_ALU_ADD;
					`CPU_SUB: alu_op = `CPU_ALU_SUB;
					`CPU_AND: alu_op = `CPU_ALU_AND;
					`CPU_OR: alu_op = `CPU_ALU_OR;
					`CPU_XOR: alu_op = `CPU_ALU_XOR;
					`CPU_SRLI: begin
						alu_op = `CPU_ALU_SRL;
						alu_src2_select = 3'd1;
					end
					`CPU_SLLI: begin
						alu_op = `CPU_ALU_SLL;
						alu_src2_select = 3'd1;
					end
					`CPU_ROTRI: begin
						alu_op = `CPU_ALU_ROTR;
						alu_src2_select = 3'd1;
					end
					default: do_reg_write = 1'b0;
				endcase
			end
			`CPU_ADDI, `CPU_ORI, `CPU_XORI, `CPU_MOVI: begin
				alu_src2_select = 3'd1;
				do_reg_write = 1'b1;
				case (opcode)
					`CPU_ADDI: imm_extend_select = 2'd1;
					`CPU_ORI: begin
						imm_extend_select = 2'd2;
						alu_op = `CPU_ALU_OR;
					end
					`CPU_XORI: begin
						imm_extend_select = 2'd2;
						alu_op = `CPU_ALU_XOR;
					end
					default: begin
						// movi writes the immediate itself
						imm_extend_select = 2'd3;
						write_reg_select = 2'd1;
					end
				endcase
			end
			`CPU_LWI: begin
				alu_src2_select = 3'd2;
				write_reg_select = 2'd2;
				dm_read = 1'b1;
				do_reg_write = 1'b1;
			end
			`CPU_SWI: begin
				alu_src2_select = 3'd2;
				dm_write = 1'b1;
			end
			`CPU_TY_LS: begin
				alu_src2_select = 3'd3;
				if (sub_ls == `CPU_LW) begin
					write_reg_select = 2'd2;
					dm_read = 1'b1;
					do_reg_write = 1'b1;
				end else if (sub_ls == `CPU_SW) begin
					dm_write = 1'b1;
				end
			end
			`CPU_TY_B: begin
				alu_src2_select = 3'd4;
				alu_op = `CPU_ALU_SUB;
			end
			default: begin
			end
		endcase
	end

	// instruction register loads only as decode ends
	a_instruction_held: assert property (@(posedge clock) disable iff (reset)
		!$past(enable_decode) |-> $stable(instruction));

endmodule

//--- register_file.sv
`timescale 1ns/1ns

module register_file (
	input logic clock,
	input logic reset,
	input cpu_pkg::reg_addr_t read_addr_a,
	input cpu_pkg::reg_addr_t read_addr_b,
	output cpu_pkg::word_t read_data_a,
	output cpu_pkg::word_t read_data_b,
	input logic write_enable,
	input cpu_pkg::reg_addr_t write_addr,
	input cpu_pkg::word_t write_data
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	// r0 is an ordinary register here
	assign read_data_a = regs[read_addr_a];
	assign read_data_b = regs[read_addr_b];

endmodule

//--- alu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module alu (
	input cpu_pkg::word_t operand_a,
	input cpu_pkg::word_t operand_b,
	input logic [3:0] alu_op,
	output cpu_pkg::word_t result,
	output logic zero
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic [63:0] doubled;

	assign shamt = operand_b[4:0];
	// rotate as a shift of the word placed twice
	assign doubled = {operand_a, operand_a} >> shamt;

	always_comb begin
		case (alu_op)
			`CPU_ALU_ADD: result = operand_a + operand_b;
			`CPU_ALU_SUB: result = operand_a - operand_b;
			`CPU_ALU_AND: result = operand_a & operand_b;
			`CPU_ALU_OR: result = operand_a | operand_b;
			`CPU_ALU_XOR: result = operand_a ^ operand_b;
			`CPU_ALU_SRL: result = operand_a >> shamt;
			`CPU_ALU_SLL: result = operand_a << shamt;
			`CPU_ALU_ROTR: result = word_t'(doubled);
			default: result = operand_a + operand_b;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- instruction_memory.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module instruction_memory #(
	parameter int depth = `CPU_IMEM_DEPTH
) (
	input logic clock,
	input logic read_enable,
	input cpu_pkg::pc_t read_addr,
	output cpu_pkg::word_t read_data,
	input logic load,
	input cpu_pkg::pc_t load_addr,
	input cpu_pkg::word_t load_data
);
	import cpu_pkg::*;

	localparam int aw = $clog2(depth);

	word_t mem [depth];

	// program load port, used while the core is held in reset
	always_ff @(posedge clock) begin
		if (load) begin
			mem[load_addr[aw-1:0]] <= load_data;
		end
	end

	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_data <= mem[read_addr[aw-1:0]];
		end
	end

	a_no_load_during_fetch: assert property (@(posedge clock) !(load && read_enable));

endmodule

//--- data_memory.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module data_memory #(
	parameter int depth = `CPU_DMEM_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic read_enable,
	input logic write_enable,
	input logic [$clog2(depth)-1:0] addr,
	input cpu_pkg::word_t write_data,
	output cpu_pkg::word_t read_data
);
	import cpu_pkg::*;

	word_t mem [depth];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (write_enable) begin
			mem[addr] <= write_data;
		end
	end

	// held until the next load or lw
	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_data <= mem[addr];
		end
	end

endmodule

//--- multicycle_cpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module multicycle_cpu (
	input logic clock,
	input logic reset,
	input logic imem_load,
	input cpu_pkg::pc_t imem_load_addr,
	input cpu_pkg::word_t imem_load_data,
	output logic retire,
	output cpu_pkg::pc_t retire_pc,
	output cpu_pkg::pc_t next_pc,
	output logic reg_we,
	output cpu_pkg::reg_addr_t reg_waddr,
	output cpu_pkg::word_t reg_wdata,
	output logic mem_we,
	output logic [$clog2(`CPU_DMEM_DEPTH)-1:0] mem_addr,
	output cpu_pkg::word_t mem_wdata
);
	import cpu_pkg::*;

	logic enable_fetch, enable_decode, enable_execute;
	logic enable_memaccess, enable_writeback, enable_pc;
	logic dm_read, dm_write, do_reg_write;
	logic alu_zero, alu_zero_q;
	logic [3:0] alu_op;
	pc_sel_t pc_select;
	alu_src2_t alu_src2_select;
	imm_ext_t imm_extend_select;
	wb_sel_t write_reg_select;
	reg_addr_t reg_ra_addr, reg_rb_addr, reg_rt_addr, rf_addr_b;
	pc_t pc_q, branch_target, jump_target;
	word_t imem_data, ir_q, rf_data_a, rf_data_b;
	word_t imm_ext, addr_offset, operand_b, alu_result, alu_result_q, dm_data;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc_q <= '0;
			ir_q <= '0;
		end else begin
			if (enable_pc)
				pc_q <= next_pc;
			if (enable_decode)
				ir_q <= imem_data;
		end
	end

	always_ff @(posedge clock) begin
		if (enable_execute) begin
			alu_result_q <= alu_result;
			alu_zero_q <= alu_zero;
		end
	end

	always_comb begin
		case (imm_extend_select)
			2'd0: imm_ext = word_t'(ir_q[`CPU_F_IMM5]);
			2'd1: imm_ext = {{17{ir_q[14]}}, ir_q[`CPU_F_IMM15]};
			2'd2: imm_ext = {17'd0, ir_q[`CPU_F_IMM15]};
			default: imm_ext = {{12{ir_q[19]}}, ir_q[`CPU_F_IMM20]};
		endcase
	end

	// lwi/swi word offset
	assign addr_offset = {{17{ir_q[14]}}, ir_q[`CPU_F_IMM15]};

	// rt shares read port b for branch compares and store data
	assign rf_addr_b = (enable_memaccess || alu_src2_select == 3'd4) ? reg_rt_addr : reg_rb_addr;

	always_comb begin
		case (alu_src2_select)
			3'd1: operand_b = imm_ext;
			3'd2: operand_b = addr_offset;
			default: operand_b = rf_data_b;
		endcase
	end

	always_comb begin
		case (write_reg_select)
			2'd1: reg_wdata = imm_ext;
			2'd2: reg_wdata = dm_data;
			default: reg_wdata = alu_result_q;
		endcase
	end

	// sign extension of imm14 folds away at pc width
	assign branch_target = pc_q + pc_t'(ir_q[`CPU_F_IMM14]);
	assign jump_target = pc_t'(ir_q[`CPU_F_IMM24]);

	always_comb begin
		case (pc_select)
			2'd1: next_pc = branch_target;
			2'd2: next_pc = jump_target;
			default: next_pc = pc_q + pc_t'(1);
		endcase
	end

	assign retire = enable_pc;
	assign retire_pc = pc_q;
	assign reg_we = enable_writeback && do_reg_write;
	assign reg_waddr = reg_rt_addr;
	assign mem_we = enable_memaccess && dm_write;
	assign mem_addr = alu_result_q[$clog2(`CPU_DMEM_DEPTH)-1:0];
	assign mem_wdata = rf_data_b;

	controller u_controller (
		.clock(clock), .reset(reset), .instruction(ir_q), .alu_zero(alu_zero_q),
		.enable_fetch(enable_fetch), .enable_decode(enable_decode),
		.enable_execute(enable_execute), .enable_memaccess(enable_memaccess),
		.enable_writeback(enable_writeback), .enable_pc(enable_pc),
		.pc_select(pc_select), .alu_src2_select(alu_src2_select),
		.imm_extend_select(imm_extend_select), .write_reg_select(write_reg_select),
		.alu_op(alu_op), .dm_read(dm_read), .dm_write(dm_write),
		.do_reg_write(do_reg_write), .reg_ra_addr(reg_ra_addr),
		.reg_rb_addr(reg_rb_addr), .reg_rt_addr(reg_rt_addr)
	);

	register_file u_register_file (
		.clock(clock), .reset(reset),
		.read_addr_a(reg_ra_addr), .read_addr_b(rf_addr_b),
		.read_data_a(rf_data_a), .read_data_b(rf_data_b),
		.write_enable(reg_we), .write_addr(reg_waddr), .write_data(reg_wdata)
	);

	alu u_alu (
		.operand_a(rf_data_a), .operand_b(operand_b), .alu_op(alu_op),
		.result(alu_result), .zero(alu_zero)
	);

	// no fetch while held in reset, the load port owns the memory then
	instruction_memory #(.depth(`CPU_IMEM_DEPTH)) u_instruction_memory (
		.clock(clock), .read_enable(enable_fetch && !reset), .read_addr(pc_q),
		.read_data(imem_data), .load(imem_load), .load_addr(imem_load_addr),
		.load_data(imem_load_data)
	);

	data_memory #(.depth(`CPU_DMEM_DEPTH)) u_data_memory (
		.clock(clock), .reset(reset),
		.read_enable(enable_memaccess && dm_read), .write_enable(mem_we),
		.addr(mem_addr), .write_data(mem_wdata), .read_data(dm_data)
	);

endmodule

//--- cpu_checker.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_checker (
	input logic clock,
	input logic reset,
	input logic imem_load,
	input cpu_pkg::pc_t imem_load_addr,
	input cpu_pkg::word_t imem_load_data,
	input logic retire,
	input cpu_pkg::pc_t retire_pc,
	input cpu_pkg::pc_t next_pc,
	input logic reg_we,
	input cpu_pkg::reg_addr_t reg_waddr,
	input cpu_pkg::word_t reg_wdata,
	input logic mem_we,
	input logic [4:0] mem_addr,
	input cpu_pkg::word_t mem_wdata,
	output logic halted,
	output int error_count,
	output int check_count,
	output int retire_count
);
	import cpu_pkg::*;

	word_t prog [`CPU_IMEM_DEPTH];
	word_t regs [32];
	word_t dmem [`CPU_DMEM_DEPTH];
	pc_t model_pc;
	pc_t prev_pc;
	logic have_prev;
	int cycle;
	int errors = 0;
	int checks = 0;
	int retired = 0;

	// events seen since the last retire
	logic seen_reg;
	logic seen_mem;
	reg_addr_t seen_reg_addr;
	word_t seen_reg_data;
	logic [4:0] seen_mem_addr;
	word_t seen_mem_data;

	assign error_count = errors;
	assign check_count = checks;
	assign retire_count = retired;

	task automatic check_value(string field, word_t expected, word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error at %0t ns: pc %0d %s expected %h, got %h",
				$time, model_pc, field, expected, actual);
		end
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// executes the instruction at model_pc and compares the observed events
	task automatic step_model();
		word_t instr;
		logic [5:0] opcode;
		word_t a;
		word_t b_reg;
		word_t t_reg;
		word_t sext15;
		word_t zext15;
		word_t value;
		logic [4:0] addr;
		int shamt;
		logic exp_reg;
		logic exp_mem;
		pc_t exp_next;

		instr = prog[model_pc[5:0]];
		opcode = instr[`CPU_F_OPCODE];
		a = regs[instr[`CPU_F_RA]];
		b_reg = regs[instr[`CPU_F_RB]];
		t_reg = regs[instr[`CPU_F_RT]];
		sext15 = {{17{instr[14]}}, instr[`CPU_F_IMM15]};
		zext15 = {17'd0, instr[`CPU_F_IMM15]};
		shamt = int'(instr[`CPU_F_IMM5]);
		exp_reg = 1'b0;
		exp_mem = 1'b0;
		value = '0;
		addr = '0;
		exp_next = model_pc + 8'd1;
		case (opcode)
			`CPU_TY_BASE: begin
				exp_reg = 1'b1;
				case (instr[`CPU_F_SUB_BASE])
					`CPU_ADD: value = a + b_reg;
					`CPU_SUB: value = a - b_reg;
					`CPU_AND: value = a & b_reg;
					`CPU_OR: value = a | b_reg;
					`CPU_XOR: value = a ^ b_reg;
					`CPU_SLLI: value = a << shamt;
					`CPU_SRLI: value = a >> shamt;
					`CPU_ROTRI: value = (a >> shamt) | (a << (32 - shamt));
					default: exp_reg = 1'b0;
				endcase
			end
			`CPU_ADDI: begin
				exp_reg = 1'b1;
				value = a + sext15;
			end
			`CPU_ORI: begin
				exp_reg = 1'b1;
				value = a | zext15;
			end
			`CPU_XORI: begin
				exp_reg = 1'b1;
				value = a ^ zext15;
			end
			`CPU_MOVI: begin
				exp_reg = 1'b1;
				value = {{12{instr[19]}}, instr[`CPU_F_IMM20]};
			end
			`CPU_LWI: begin
				exp_reg = 1'b1;
				addr = 5'(a + sext15);
				value = dmem[addr];
			end
			`CPU_SWI: begin
				exp_mem = 1'b1;
				addr = 5'(a + sext15);
				value = t_reg;
			end
			`CPU_TY_LS: begin
				addr = 5'(a + b_reg);
				if (instr[`CPU_F_SUB_LS] == `CPU_LW) begin
					exp_reg = 1'b1;
					value = dmem[addr];
				end else if (instr[`CPU_F_SUB_LS] == `CPU_SW) begin
					exp_mem = 1'b1;
					value = t_reg;
				end
			end
			`CPU_TY_B: begin
				// beq taken on equal, bne on differ
				if ((a == t_reg) ^ instr[`CPU_F_SUB_B]) begin
					exp_next = model_pc + pc_t'({{18{instr[13]}}, instr[`CPU_F_IMM14]});
				end
			end
			`CPU_JJ: exp_next = pc_t'(instr[`CPU_F_IMM24]);
			default: begin
			end
		endcase

		check_value("retire_pc", word_t'(model_pc), word_t'(retire_pc));
		if (exp_reg != seen_reg) begin
			report_failure($sformatf("pc %0d register write %s", model_pc,
				exp_reg ? "missing" : "not expected"));
		end else if (exp_reg) begin
			check_value("reg_waddr", word_t'(instr[`CPU_F_RT]), word_t'(seen_reg_addr));
			check_value("reg_wdata", value, seen_reg_data);
		end
		if (exp_mem != seen_mem) begin
			report_failure($sformatf("pc %0d store %s", model_pc,
				exp_mem ? "missing" : "not expected"));
		end else if (exp_mem) begin
			check_value("mem_addr", word_t'(addr), word_t'(seen_mem_addr));
			check_value("mem_wdata", value, seen_mem_data);
		end
		check_value("next_pc", word_t'(exp_next), word_t'(next_pc));

		if (exp_reg) begin
			regs[instr[`CPU_F_RT]] = value;
		end
		if (exp_mem) begin
			dmem[addr] = value;
		end
		model_pc = exp_next;
	endtask

	always @(posedge clock) begin
		if (imem_load) begin
			prog[imem_load_addr[5:0]] = imem_load_data;
		end
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] = '0;
			end
			for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
				dmem[i] = '0;
			end
			model_pc = '0;
			prev_pc = '0;
			have_prev = 1'b0;
			halted = 1'b0;
			cycle = 0;
			seen_reg = 1'b0;
			seen_mem = 1'b0;
		end else begin
			// cycle 4 is memory access, 5 writeback, 6 pc update
			cycle++;
			if (mem_we) begin
				if (cycle != 4) begin
					report_failure("store outside the memory access state");
				end
				seen_mem = 1'b1;
				seen_mem_addr = mem_addr;
				seen_mem_data = mem_wdata;
			end
			if (reg_we) begin
				if (cycle != 5) begin
					report_failure("register write outside the writeback state");
				end
				seen_reg = 1'b1;
				seen_reg_addr = reg_waddr;
				seen_reg_data = reg_wdata;
			end
			if (retire) begin
				if (cycle != 6) begin
					report_failure($sformatf("retire came %0d cycles after the last one", cycle));
				end
				step_model();
				retired++;
				// a forward-only program repeats a pc only in its halt loop
				if (have_prev && retire_pc == prev_pc) begin
					halted = 1'b1;
				end
				prev_pc = retire_pc;
				have_prev = 1'b1;
				cycle = 0;
				seen_reg = 1'b0;
				seen_mem = 1'b0;
			end
		end
	end

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam int num_tests = 4;
	// every word of every program at six cycles each, plus margin
	localparam int cycle_limit = num_tests * `CPU_IMEM_DEPTH * 6 + 200;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic imem_load = 1'b0;
	pc_t imem_load_addr = '0;
	word_t imem_load_data = '0;

	logic retire;
	pc_t retire_pc;
	pc_t next_pc;
	logic reg_we;
	reg_addr_t reg_waddr;
	word_t reg_wdata;
	logic mem_we;
	logic [4:0] mem_addr;
	word_t mem_wdata;

	logic halted;
	int error_count;
	int check_count;
	int retire_count;
	int run_cycles = 0;
	word_t program_words [`CPU_IMEM_DEPTH];

	always #4 clock = ~clock;

	multicycle_cpu dut0 (
		.clock(clock), .reset(reset),
		.imem_load(imem_load), .imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.retire(retire), .retire_pc(retire_pc), .next_pc(next_pc),
		.reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	cpu_checker checker0 (
		.clock(clock), .reset(reset),
		.imem_load(imem_load), .imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.retire(retire), .retire_pc(retire_pc), .next_pc(next_pc),
		.reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.halted(halted), .error_count(error_count),
		.check_count(check_count), .retire_count(retire_count)
	);

	// load phases do not count
	always @(posedge clock) begin
		if (!reset) begin
			run_cycles++;
			if (run_cycles >= cycle_limit) begin
				$display("Timeout: no halt loop reached within %0d run cycles", cycle_limit);
				$display("ERRORS FOUND");
				$finish;
			end
		end
	end

	function automatic word_t encode(logic [5:0] opcode, reg_addr_t rt, reg_addr_t ra,
		logic [14:0] low);
		return {1'b0, opcode, rt, ra, low};
	endfunction

	// short forward hops keep most of the program reachable
	function automatic pc_t forward_target(int index);
		int reach;
		reach = `CPU_IMEM_DEPTH - 1 - index;
		if (reach > 8) begin
			reach = 8;
		end
		return pc_t'(index + int'($urandom_range(reach, 1)));
	endfunction

	task automatic make_program();
		reg_addr_t rt;
		reg_addr_t ra;
		reg_addr_t rb;
		logic [14:0] imm;
		logic [19:0] imm20;
		pc_t target;
		pc_t offset;
		for (int i = 0; i < `CPU_IMEM_DEPTH - 1; i++) begin
			rt = reg_addr_t'($urandom());
			ra = reg_addr_t'($urandom());
			rb = reg_addr_t'($urandom());
			imm = 15'($urandom());
			imm20 = 20'($urandom());
			target = forward_target(i);
			offset = target - pc_t'(i);
			case ($urandom_range(19, 0))
				0: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {rb, 5'd0, `CPU_ADD});
				1: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {rb, 5'd0, `CPU_SUB});
				2: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {rb, 5'd0, `CPU_AND});
				3: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {rb, 5'd0, `CPU_OR});
				4: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {rb, 5'd0, `CPU_XOR});
				5: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {imm[4:0], 5'd0, `CPU_SLLI});
				6: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {imm[4:0], 5'd0, `CPU_SRLI});
				7: program_words[i] = encode(`CPU_TY_BASE, rt, ra, {imm[4:0], 5'd0, `CPU_ROTRI});
				8: program_words[i] = encode(`CPU_ADDI, rt, ra, imm);
				9: program_words[i] = encode(`CPU_ORI, rt, ra, imm);
				10: program_words[i] = encode(`CPU_XORI, rt, ra, imm);
				11: program_words[i] = encode(`CPU_LWI, rt, ra, imm);
				12: program_words[i] = encode(`CPU_SWI, rt, ra, imm);
				13: program_words[i] = encode(`CPU_TY_LS, rt, ra, {rb, 2'b00, `CPU_LW});
				14: program_words[i] = encode(`CPU_TY_LS, rt, ra, {rb, 2'b00, `CPU_SW});
				15: program_words[i] = encode(`CPU_TY_B, rt, ra, {`CPU_BEQ, 6'd0, offset});
				16: program_words[i] = encode(`CPU_TY_B, rt, ra, {`CPU_BNE, 6'd0, offset});
				17: program_words[i] = {1'b0, `CPU_JJ, 1'b0, 16'd0, target};
				default: program_words[i] = encode(`CPU_MOVI, rt, imm20[19:15], imm20[14:0]);
			endcase
		end
		// jump to itself as the halt
		program_words[`CPU_IMEM_DEPTH - 1] =
			{1'b0, `CPU_JJ, 1'b0, 16'd0, pc_t'(`CPU_IMEM_DEPTH - 1)};
	endtask

	task automatic load_program();
		for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
			@(posedge clock);
			#1;
			imem_load = 1'b1;
			imem_load_addr = pc_t'(i);
			imem_load_data = program_words[i];
		end
		@(posedge clock);
		#1;
		imem_load = 1'b0;
	endtask

	initial begin
		int errors_before;
		int retired_before;
		void'($urandom(32'he98c));
		for (int t = 0; t < num_tests; t++) begin
			errors_before = error_count;
			retired_before = retire_count;
			make_program();
			@(posedge clock);
			#1;
			reset = 1'b1;
			repeat (5) @(posedge clock);
			load_program();
			@(posedge clock);
			#1;
			reset = 1'b0;
			wait (halted === 1'b1);
			$display("test %0d: %0d instructions retired, %0d errors", t,
				retire_count - retired_before, error_count - errors_before);
		end
		$display("%0d tests, %0d instructions retired, %0d checks, %0d errors",
			num_tests, retire_count, check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- multicycle_cpu.f
+incdir+.
cpu_pkg.sv
controller.sv
register_file.sv
alu.sv
instruction_memory.sv
data_memory.sv
multicycle_cpu.sv
cpu_checker.sv
tb_cpu.sv

//--- run.sh
#!/bin/bash
# build the testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu -f multicycle_cpu.f -o sim_cpu \
	&& ./obj_dir/sim_cpu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
